// ==== sources.f ====
src/mboxPkg.sv
src/chanPkg.sv
src/mbCfgRegs.sv
src/memBufBank.sv
src/chanBuffer.sv
src/mbox.sv
verif/mboxTb.sv

// ==== src/chanBuffer.sv ====
`timescale 1ns/1ns

module chanBuffer
  import mboxPkg::*;
  import chanPkg::*;
(
  input  logic      clk,
  input  logic      rstN,
  input  mbOpE      op,
  input  chBufAddrT opAddr,
  input  wordT      mbWord,
  input  wordT      cbusIn,
  input  logic      chReverse,
  input  wordT      ccwIn,
  input  logic      chBufMbSrc,
  input  logic      mixMbSel,
  input  ccwAddrT   ccwAddr,
  output wordT      chBufOut,
  output wordT      chReg,
  output wordT      ccwMix
);

  wordT chBuf [chBufDepth];
  wordT ccwBuf [ccwDepth];
  wordT chBufIn;
  wordT chRegIn;
  logic chBufWe;
  logic chBufRe;
  logic chRegLd;
  logic ccwWe;

  // Opcode decode
  assign chBufWe = (op == OpChBufWrite);
  assign chBufRe = (op == OpChBufRead);
  assign chRegLd = (op == OpChRegLoad);
  assign ccwWe   = (op == OpCcwWrite);

  // Buffer fills from the memory buffer or from the channel register
  assign chBufIn = chBufMbSrc ? mbWord : chReg;

  // Halfword swap on the channel bus word
  assign chRegIn = chReverse ? {cbusIn[halfW:wordW-1], cbusIn[0:halfW-1]} : cbusIn;

  // Channel buffer RAM keeps its contents through reset
  always_ff @(posedge clk) begin
    if (chBufWe) begin
      chBuf[opAddr] <= chBufIn;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      chBufOut <= '0;
      chReg    <= '0;
      ccwBuf   <= '{default: '0};
    end else begin
      // Registered read port holds until the next read
      if (chBufRe) begin
        chBufOut <= chBuf[opAddr];
      end
      if (chRegLd) begin
        chReg <= chRegIn;
      end
      if (ccwWe) begin
        ccwBuf[opAddr[ccwAddrW-1:0]] <= ccwIn;
      end
    end
  end

  assign ccwMix = mixMbSel ? mbWord : ccwBuf[ccwAddr];

  bufAddrKnown: assert property (
    @(posedge clk) disable iff (!rstN)
    (chBufWe || chBufRe || ccwWe) |-> !$isunknown(opAddr)
  ) else $error("opAddr unknown during buffer operation");

endmodule

// ==== src/chanPkg.sv ====
package chanPkg;

  // Channel buffer RAM geometry
  localparam int chBufDepth = 128;
  localparam int chBufAddrW = $clog2(chBufDepth);

  typedef logic [chBufAddrW-1:0] chBufAddrT;

  // CCW buffer geometry
  localparam int ccwDepth = 4;
  localparam int ccwAddrW = $clog2(ccwDepth);

  typedef logic [ccwAddrW-1:0] ccwAddrT;

endpackage

// ==== src/mbCfgRegs.sv ====
`timescale 1ns/1ns

module mbCfgRegs
  import mboxPkg::*;
  import chanPkg::*;
(
  input  logic                clk,
  input  logic                rstN,
  input  logic                cfgWrEn,
  input  cfgRegE              cfgAddr,
  input  logic [cfgDataW-1:0] cfgData,
  output mbSlotT              mbSel,
  output memToCacheE          mtcSel,
  output logic                mtcEn,
  output logic                pagingMode,
  output logic                chBufMbSrc,
  output logic                mixMbSel,
  output ccwAddrT             ccwAddr
);

  // Each steering field takes the low bits of the write data
  always_ff @(posedge clk) begin
    if (!rstN) begin
      mbSel      <= '0;
      mtcSel     <= MtcAr;
      mtcEn      <= 1'b0;
      pagingMode <= 1'b0;
      chBufMbSrc <= 1'b0;
      mixMbSel   <= 1'b0;
      ccwAddr    <= '0;
    end else if (cfgWrEn) begin
      case (cfgAddr)
        CfgMbSel: begin
          mbSel <= cfgData[$bits(mbSlotT)-1:0];
        end
        CfgMtcSel: begin
          mtcSel <= memToCacheE'(cfgData[$bits(memToCacheE)-1:0]);
        end
        CfgMtcEn: begin
          mtcEn <= cfgData[0];
        end
        CfgPaging: begin
          pagingMode <= cfgData[0];
        end
        CfgChBufSrc: begin
          chBufMbSrc <= cfgData[0];
        end
        CfgMixSel: begin
          mixMbSel <= cfgData[0];
        end
        CfgCcwAddr: begin
          ccwAddr <= cfgData[$bits(ccwAddrT)-1:0];
        end
        // Unmapped address, write dropped
        default: begin
        end
      endcase
    end
  end

  // A write needs a clean address or a random field gets hit
  cfgAddrKnown: assert property (
    @(posedge clk) disable iff (!rstN)
    cfgWrEn |-> !$isunknown(cfgAddr)
  ) else $error("cfgAddr unknown during configuration write");

endmodule

// ==== src/mbox.sv ====
`timescale 1ns/1ns

module mbox
  import mboxPkg::*;
  import chanPkg::*;
(
  input  logic                clk,
  input  logic                rstN,
  input  logic                cfgWrEn,
  input  cfgRegE              cfgAddr,
  input  logic [cfgDataW-1:0] cfgData,
  input  mbOpE                op,
  input  mbSlotT              opSlot,
  input  mbSrcE               opSrc,
  input  chBufAddrT           opAddr,
  input  logic                nxm,
  input  wordT                arData,
  input  wordT                cacheData,
  input  wordT                memData,
  input  wordT                cbusIn,
  input  logic                chReverse,
  input  wordT                ccwIn,
  output wordT                mbWord,
  output logic                mbParOdd,
  output wordT                memToCache,
  output wordT                ptIn,
  output wordT                cbusOut,
  output wordT                ccwMix
);

  // Steering fields from the configuration block
  mbSlotT     mbSel;
  memToCacheE mtcSel;
  logic       mtcEn;
  logic       pagingMode;
  logic       chBufMbSrc;
  logic       mixMbSel;
  ccwAddrT    ccwAddr;

  wordT chReg;

  mbCfgRegs cfgRegs (
    .clk, .rstN, .cfgWrEn, .cfgAddr, .cfgData,
    .mbSel, .mtcSel, .mtcEn, .pagingMode,
    .chBufMbSrc, .mixMbSel, .ccwAddr
  );

  memBufBank memBuf (
    .clk, .rstN, .op, .opSlot, .opSrc, .nxm,
    .arData, .cacheData, .memData,
    .chBufOut(cbusOut), .chReg, .ccwMix,
    .mbSel, .mtcSel, .mtcEn, .pagingMode,
    .mbWord, .mbParOdd, .memToCache, .ptIn
  );

  // The registered buffer word also drives the channel bus
  chanBuffer chanBuf (
    .clk, .rstN, .op, .opAddr, .mbWord, .cbusIn, .chReverse, .ccwIn,
    .chBufMbSrc, .mixMbSel, .ccwAddr,
    .chBufOut(cbusOut), .chReg, .ccwMix
  );

endmodule

// ==== src/mboxPkg.sv ====
package mboxPkg;

  // Word geometry of the memory box
  localparam int wordW = 36;
  localparam int halfW = wordW / 2;
  localparam int mbSlots = 4;

  // Width of a configuration register write
  localparam int cfgDataW = 8;

  typedef logic [0:wordW-1] wordT;
  typedef logic [$clog2(mbSlots)-1:0] mbSlotT;

  // Datapath operations, one per cycle
  typedef enum logic [2:0] {
    OpNone       = 3'd0,
    OpLoadMb     = 3'd1,
    OpChBufWrite = 3'd2,
    OpChBufRead  = 3'd3,
    OpChRegLoad  = 3'd4,
    OpCcwWrite   = 3'd5
  } mbOpE;

  // Memory buffer load sources
  typedef enum logic [2:0] {
    SrcCache  = 3'd0,
    SrcAr     = 3'd1,
    SrcMem    = 3'd2,
    SrcCcwMix = 3'd3,
    SrcChBuf  = 3'd4
  } mbSrcE;

  // Memory-to-cache sources
  typedef enum logic [1:0] {
    MtcAr    = 2'd0,
    MtcMb    = 2'd1,
    MtcMem   = 2'd2,
    MtcChReg = 2'd3
  } memToCacheE;

  // Configuration register map
  typedef enum logic [2:0] {
    CfgMbSel    = 3'd0,
    CfgMtcSel   = 3'd1,
    CfgMtcEn    = 3'd2,
    CfgPaging   = 3'd3,
    CfgChBufSrc = 3'd4,
    CfgMixSel   = 3'd5,
    CfgCcwAddr  = 3'd6
  } cfgRegE;

endpackage

// ==== src/memBufBank.sv ====
`timescale 1ns/1ns

module memBufBank
  import mboxPkg::*;
(
  input  logic       clk,
  input  logic       rstN,
  input  mbOpE       op,
  input  mbSlotT     opSlot,
  input  mbSrcE      opSrc,
  input  logic       nxm,
  input  wordT       arData,
  input  wordT       cacheData,
  input  wordT       memData,
  input  wordT       chBufOut,
  input  wordT       chReg,
  input  wordT       ccwMix,
  input  mbSlotT     mbSel,
  input  memToCacheE mtcSel,
  input  logic       mtcEn,
  input  logic       pagingMode,
  output wordT       mbWord,
  output logic       mbParOdd,
  output wordT       memToCache,
  output wordT       ptIn
);

  // The four memory buffer words
  wordT mbWords [mbSlots];
  wordT mbIn;
  logic mbLoad;

  // Non-existent memory blocks every buffer load
  assign mbLoad = (op == OpLoadMb) && !nxm;

  // Load source mux
  always_comb begin
    case (opSrc)
      SrcCache:  mbIn = cacheData;
      SrcAr:     mbIn = arData;
      SrcMem:    mbIn = memData;
      SrcCcwMix: mbIn = ccwMix;
      SrcChBuf:  mbIn = chBufOut;
      default:   mbIn = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      mbWords <= '{default: '0};
    end else if (mbLoad) begin
      mbWords[opSlot] <= mbIn;
    end
  end

  // Slot selector drives the shared buffer word
  assign mbWord = mbWords[mbSel];

  assign mbParOdd = ^mbWord;

  // Page table sees AR unless paging mode steers it to the buffer
  assign ptIn = pagingMode ? mbWord : arData;

  always_comb begin
    if (mtcEn) begin
      case (mtcSel)
        MtcAr:    memToCache = arData;
        MtcMb:    memToCache = mbWord;
        MtcMem:   memToCache = memData;
        MtcChReg: memToCache = chReg;
        default:  memToCache = '0;
      endcase
    end else begin
      memToCache = '0;
    end
  end

  // The control side must pick a real source when it loads a slot
  loadSrcDefined: assert property (
    @(posedge clk) disable iff (!rstN)
    (op == OpLoadMb) |->
      (opSrc inside {SrcCache, SrcAr, SrcMem, SrcCcwMix, SrcChBuf})
  ) else $error("undefined memory buffer source on load");

endmodule

// ==== verif/mboxTb.sv ====
`timescale 1ns/1ns

module mboxTb
  import mboxPkg::*;
  import chanPkg::*;
();

  localparam int clkPeriod = 8;
  localparam int seed = 58;
  localparam int nBuf = 16;
  // Reset, slot loads, nxm, mux sweep, channel buffer, swap, CCW, tail
  localparam int testCycles = 3 + mbSlots * (1 + mbSlots * 5) + mbSlots + 48
                              + 2 + 8 * nBuf + 8 + 22 + 2;

  logic                clk;
  logic                rstN;
  logic                cfgWrEn;
  cfgRegE              cfgAddr;
  logic [cfgDataW-1:0] cfgData;
  mbOpE                op;
  mbSlotT              opSlot;
  mbSrcE               opSrc;
  chBufAddrT           opAddr;
  logic                nxm;
  wordT                arData;
  wordT                cacheData;
  wordT                memData;
  wordT                cbusIn;
  logic                chReverse;
  wordT                ccwIn;
  wordT                mbWord;
  logic                mbParOdd;
  wordT                memToCache;
  wordT                ptIn;
  wordT                cbusOut;
  wordT                ccwMix;

  // Reference state, zero as after reset
  wordT       mMb [mbSlots] = '{default: '0};
  wordT       mCcw [ccwDepth] = '{default: '0};
  wordT       mChBuf [chBufDepth];
  wordT       mChReg = '0;
  wordT       mChBufOut = '0;
  mbSlotT     mSel = '0;
  memToCacheE mMtcSel = MtcAr;
  logic       mMtcEn = 1'b0;
  logic       mPaging = 1'b0;
  logic       mChSrc = 1'b0;
  logic       mMixSel = 1'b0;
  ccwAddrT    mCcwAddr = '0;

  // Expected outputs for the current cycle
  wordT eMbWord;
  logic eParOdd;
  wordT eMtc;
  wordT ePtIn;
  wordT eCbusOut;
  wordT eCcwMix;

  mbox uut (
    .clk, .rstN, .cfgWrEn, .cfgAddr, .cfgData,
    .op, .opSlot, .opSrc, .opAddr, .nxm,
    .arData, .cacheData, .memData, .cbusIn, .chReverse, .ccwIn,
    .mbWord, .mbParOdd, .memToCache, .ptIn, .cbusOut, .ccwMix
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(clkPeriod / 2) clk = ~clk;
    end
  end

  function automatic wordT randWord();
    logic [63:0] r;
    r = {$urandom, $urandom};
    return r[wordW-1:0];
  endfunction

  // Outputs from the current state, then the state after the coming edge
  function automatic void refStep();
    wordT src;
    logic [wordW-1:0] raw;
    int ones;
    eMbWord = mMb[mSel];
    ones = 0;
    for (int i = 0; i < wordW; i++) begin
      ones += eMbWord[i];
    end
    eParOdd = ones % 2;
    ePtIn = mPaging ? eMbWord : arData;
    if (!mMtcEn) begin
      eMtc = '0;
    end else begin
      case (mMtcSel)
        MtcAr:   eMtc = arData;
        MtcMb:   eMtc = eMbWord;
        MtcMem:  eMtc = memData;
        default: eMtc = mChReg;
      endcase
    end
    eCbusOut = mChBufOut;
    eCcwMix = mMixSel ? eMbWord : mCcw[mCcwAddr];
    if (!rstN) begin
      mMb = '{default: '0};
      mCcw = '{default: '0};
      mChReg = '0;
      mChBufOut = '0;
      mSel = '0;
      mMtcSel = MtcAr;
      mMtcEn = 1'b0;
      mPaging = 1'b0;
      mChSrc = 1'b0;
      mMixSel = 1'b0;
      mCcwAddr = '0;
    end else begin
      case (op)
        OpLoadMb: begin
          if (!nxm) begin
            case (opSrc)
              SrcCache:  src = cacheData;
              SrcAr:     src = arData;
              SrcMem:    src = memData;
              SrcCcwMix: src = eCcwMix;
              default:   src = eCbusOut;
            endcase
            mMb[opSlot] = src;
          end
        end
        OpChBufWrite: mChBuf[opAddr] = mChSrc ? eMbWord : mChReg;
        OpChBufRead:  mChBufOut = mChBuf[opAddr];
        OpChRegLoad: begin
          raw = cbusIn;
          mChReg = chReverse ? {raw[halfW-1:0], raw[wordW-1:halfW]} : cbusIn;
        end
        OpCcwWrite:   mCcw[ccwAddrT'(opAddr)] = ccwIn;
        default: ;
      endcase
      if (cfgWrEn) begin
        case (cfgAddr)
          CfgMbSel:    mSel = cfgData[1:0];
          CfgMtcSel:   mMtcSel = memToCacheE'(cfgData[1:0]);
          CfgMtcEn:    mMtcEn = cfgData[0];
          CfgPaging:   mPaging = cfgData[0];
          CfgChBufSrc: mChSrc = cfgData[0];
          CfgMixSel:   mMixSel = cfgData[0];
          CfgCcwAddr:  mCcwAddr = cfgData[1:0];
          default: ;
        endcase
      end
    end
  endfunction

  task automatic checkWord(string name, wordT act, wordT exp);
    if (act !== exp) begin
      $display("** Error: %s expected 0x%h actual 0x%h at %0t", name, exp, act, $time);
      $display("tests failed");
      $fatal(1);
    end
  endtask

  task automatic checkBit(string name, logic act, logic exp);
    if (act !== exp) begin
      $display("** Error: %s expected 0x%h actual 0x%h at %0t", name, exp, act, $time);
      $display("tests failed");
      $fatal(1);
    end
  endtask

  // Sample just before each rising edge
  initial begin
    forever begin
      @(posedge clk);
      #(clkPeriod - 1);
      refStep();
      checkWord("mbWord", mbWord, eMbWord);
      checkBit("mbParOdd", mbParOdd, eParOdd);
      checkWord("memToCache", memToCache, eMtc);
      checkWord("ptIn", ptIn, ePtIn);
      checkWord("cbusOut", cbusOut, eCbusOut);
      checkWord("ccwMix", ccwMix, eCcwMix);
    end
  end

  initial begin
    #(testCycles * clkPeriod * 2);
    $display("watchdog timed out before the stimulus finished");
    $display("tests failed");
    $fatal(1);
  end

  // Step to 1 ns past the next edge with fresh data and no strobes
  task automatic nextCycle();
    @(posedge clk);
    #1;
    op = OpNone;
    cfgWrEn = 1'b0;
    arData = randWord();
    cacheData = randWord();
    memData = randWord();
    cbusIn = randWord();
    ccwIn = randWord();
  endtask

  task automatic issue(mbOpE o);
    op = o;
    nextCycle();
  endtask

  task automatic writeCfg(cfgRegE addr, int data);
    cfgWrEn = 1'b1;
    cfgAddr = addr;
    cfgData = cfgDataW'(data);
    nextCycle();
  endtask

  task automatic loadMb(mbSlotT slot, mbSrcE src);
    opSlot = slot;
    opSrc = src;
    issue(OpLoadMb);
  endtask

  initial begin
    mbSlotT curSel;
    chBufAddrT addrs [$];
    chBufAddrT a;
    void'($urandom(seed));
    rstN = 1'b0;
    cfgWrEn = 1'b0;
    cfgAddr = CfgMbSel;
    cfgData = '0;
    op = OpNone;
    opSlot = '0;
    opSrc = SrcCache;
    opAddr = '0;
    nxm = 1'b0;
    arData = '0;
    cacheData = '0;
    memData = '0;
    cbusIn = '0;
    chReverse = 1'b0;
    ccwIn = '0;
    repeat (2) @(posedge clk);
    #1;
    rstN = 1'b1;
    // One quiet cycle so the reset outputs get checked with zero inputs
    @(posedge clk);
    #1;

    // Every slot from every source, under every slot selection
    for (int sel = 0; sel < mbSlots; sel++) begin
      writeCfg(CfgMbSel, sel);
      curSel = mbSlotT'(sel);
      for (int slot = 0; slot < mbSlots; slot++) begin
        for (int s = 0; s <= SrcChBuf; s++) begin
          loadMb(mbSlotT'(slot), mbSrcE'(s));
        end
      end
    end
    nxm = 1'b1;
    for (int slot = 0; slot < mbSlots; slot++) begin
      loadMb(mbSlotT'(slot), SrcMem);
    end
    nxm = 1'b0;

    // Memory-to-cache and page table muxes
    for (int en = 0; en < 2; en++) begin
      for (int sel = 0; sel < 4; sel++) begin
        for (int pg = 0; pg < 2; pg++) begin
          writeCfg(CfgMtcEn, en);
          writeCfg(CfgMtcSel, sel);
          writeCfg(CfgPaging, pg);
        end
      end
    end

    // Channel buffer fill from the memory buffer, then from chReg
    writeCfg(CfgChBufSrc, 1);
    for (int i = 0; i < nBuf; i++) begin
      a = chBufAddrT'($urandom);
      addrs.push_back(a);
      loadMb(curSel, SrcAr);
      opAddr = a;
      issue(OpChBufWrite);
    end
    writeCfg(CfgChBufSrc, 0);
    for (int i = 0; i < nBuf; i++) begin
      a = chBufAddrT'($urandom);
      addrs.push_back(a);
      issue(OpChRegLoad);
      opAddr = a;
      issue(OpChBufWrite);
    end
    foreach (addrs[i]) begin
      opAddr = addrs[i];
      issue(OpChBufRead);
      loadMb(curSel, SrcChBuf);
    end

    // Halfword swap through chReg into the buffer and back out
    writeCfg(CfgMtcEn, 1);
    writeCfg(CfgMtcSel, MtcChReg);
    for (int rev = 0; rev < 2; rev++) begin
      chReverse = rev[0];
      issue(OpChRegLoad);
      chReverse = 1'b0;
      opAddr = chBufAddrT'($urandom);
      issue(OpChBufWrite);
      issue(OpChBufRead);
    end

    // CCW buffer and the mix
    for (int e = 0; e < ccwDepth; e++) begin
      opAddr = chBufAddrT'(e);
      issue(OpCcwWrite);
    end
    for (int mix = 0; mix < 2; mix++) begin
      writeCfg(CfgMixSel, mix);
      for (int e = 0; e < ccwDepth; e++) begin
        writeCfg(CfgCcwAddr, e);
        loadMb(curSel, SrcCcwMix);
      end
    end

    issue(OpNone);
    issue(OpNone);
    $display("all tests passed");
    $finish;
  end

endmodule
